//--- verilog.f
hdl/ooo_pkg.sv
hdl/rs_entry.sv
hdl/reservation_station.sv
hdl/issue_select.sv
hdl/alu_stage.sv
hdl/ooo_issue_top.sv
testbench/ooo_issue_tb.sv

//--- Bender.yml
package:
  name: ooo_issue

sources:
  - hdl/ooo_pkg.sv
  - hdl/rs_entry.sv
  - hdl/reservation_station.sv
  - hdl/issue_select.sv
  - hdl/alu_stage.sv
  - hdl/ooo_issue_top.sv
  - target: test
    files:
      - testbench/ooo_issue_tb.sv

//--- testbench/ooo_issue_tb.sv
`timescale 1ns/1ps

// self-checking testbench, plays decoder, map table and rob around the issue subsystem
module ooo_issue_tb import ooo_pkg::*; ();

    // one stimulus row, src = -1 means immediate, otherwise the producing row
    typedef struct packed {
        alu_func_e         func;
        logic signed [7:0] src1;
        logic signed [7:0] src2;
        data_t             imm1;
        data_t             imm2;
        logic              rnd;   // replace both immediates by random values
        logic signed [4:0] gap;   // idle cycles before dispatch, -1 = random 0..3
        logic              wake;  // src1 producer must be live on the cdb at accept
    } row_t;

    logic      clock = 1'b0;
    logic      reset;
    logic      dispatch_valid;
    alu_func_e dispatch_func;
    rob_tag_t  dispatch_dest;
    rob_tag_t  rs1_tag;
    data_t     rs1_value;
    rob_tag_t  rs2_tag;
    data_t     rs2_value;
    logic      rs_full;
    logic      cdb_valid;
    rob_tag_t  cdb_tag;
    data_t     cdb_value;

    row_t  stim [$];
    data_t exp_val  [64];   // model result per row
    bit    accepted [64];
    bit    done     [64];   // seen on the cdb
    bit    full_seen;

    ooo_issue_top ooo_issue_top_i (.*);

    always #20 clock = ~clock;  // 40 ns period

    function automatic row_t mk_row(alu_func_e f, int s1, int s2, data_t a, data_t b,
                                    bit rnd, int gap, bit wake);
        row_t r;
        r.func = f;
        r.src1 = s1;
        r.src2 = s2;
        r.imm1 = a;
        r.imm2 = b;
        r.rnd  = rnd;
        r.gap  = gap;
        r.wake = wake;
        return r;
    endfunction

    task automatic load_table();
        // independent rows covering all eight functions
        stim.push_back(mk_row(ALU_ADD, -1, -1, 0, 0, 1, -1, 0));
        stim.push_back(mk_row(ALU_SUB, -1, -1, 0, 0, 1, -1, 0));
        stim.push_back(mk_row(ALU_AND, -1, -1, 0, 0, 1, -1, 0));
        stim.push_back(mk_row(ALU_OR,  -1, -1, 0, 0, 1, -1, 0));
        stim.push_back(mk_row(ALU_XOR, -1, -1, 0, 0, 1, -1, 0));
        stim.push_back(mk_row(ALU_SLL, -1, -1, 32'h1234_5679, 32'd37, 0, -1, 0)); // shamt 5
        stim.push_back(mk_row(ALU_SRL, -1, -1, 32'hf000_00f0, 32'hffff_ffe4, 0, -1, 0));
        stim.push_back(mk_row(ALU_SLT, -1, -1, 32'hffff_fff6, 32'd5, 0, -1, 0)); // -10 < 5
        stim.push_back(mk_row(ALU_SLT, -1, -1, 32'd5, 32'hffff_fff6, 0, -1, 0));
        // short dependency chain
        stim.push_back(mk_row(ALU_ADD, -1, -1, 0, 0, 1, 6, 0));
        stim.push_back(mk_row(ALU_SUB,  9, -1, 0, 0, 1, 0, 0));
        stim.push_back(mk_row(ALU_XOR, 10,  9, 0, 0, 0, 0, 0));
        stim.push_back(mk_row(ALU_SLT, 11, 10, 0, 0, 0, 0, 0));
        // producer alone in the rs, consumer lands on its broadcast cycle
        stim.push_back(mk_row(ALU_ADD, -1, -1, 0, 0, 1, 14, 0));
        stim.push_back(mk_row(ALU_OR,  13, -1, 0, 0, 1, 2, 1));
        stim.push_back(mk_row(ALU_AND, 13, -1, 0, 0, 1, 0, 0)); // value via map table
        // dependent burst, fills all four entries
        stim.push_back(mk_row(ALU_ADD, -1, -1, 0, 0, 1, 4, 0));
        stim.push_back(mk_row(ALU_SUB, 16, -1, 0, 0, 1, 0, 0));
        stim.push_back(mk_row(ALU_ADD, 17, 16, 0, 0, 0, 0, 0));
        stim.push_back(mk_row(ALU_XOR, 18, -1, 0, 0, 1, 0, 0));
        stim.push_back(mk_row(ALU_SLL, 19, -1, 0, 32'd35, 0, 0, 0));
        stim.push_back(mk_row(ALU_OR,  20, 18, 0, 0, 0, 0, 0));
        stim.push_back(mk_row(ALU_AND, 21, -1, 0, 0, 1, 0, 0));
        stim.push_back(mk_row(ALU_SLT, 22, 17, 0, 0, 0, 0, 0));
        stim.push_back(mk_row(ALU_SRL, 23, -1, 0, 32'd33, 0, 0, 0));
    endtask

    // rob allocation, tags 1..15 in turn
    function automatic rob_tag_t row_tag(int i);
        return rob_tag_t'((i % (ROB_LEN - 1)) + 1);
    endfunction

    // reference alu behavior
    function automatic data_t alu_model(alu_func_e f, data_t a, data_t b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic compare_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic compare_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    function automatic bit tag_in_flight(int i);
        for (int r = 0; r < i; r++)
            if (accepted[r] && !done[r] && row_tag(r) == row_tag(i))
                return 1'b1;
        return 1'b0;
    endfunction

    // map table lookup for one source
    task automatic resolve_source(input int src, input data_t imm, output rob_tag_t tag,
                                  output data_t bus_val, output data_t model_val);
        if (src < 0) begin
            tag       = '0;
            bus_val   = imm;
            model_val = imm;
        end else if (done[src]) begin
            tag       = '0;               // already broadcast, forward the value
            bus_val   = exp_val[src];
            model_val = exp_val[src];
        end else begin
            tag       = row_tag(src);
            bus_val   = $urandom;         // junk, must be ignored
            model_val = exp_val[src];
        end
    endtask

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic dispatch_row(input int i);
        row_t  row;
        data_t a;
        data_t b;
        data_t m1;
        data_t m2;
        int    gap;
        int    waited;
        bit    taken;
        row = stim[i];
        a   = row.rnd ? data_t'($urandom) : row.imm1;
        b   = row.rnd ? data_t'($urandom) : row.imm2;
        gap = (row.gap < 0) ? int'($urandom % 4) : int'(row.gap);
        repeat (gap) begin
            dispatch_valid = 1'b0;
            @(negedge clock);
        end
        waited = 0;
        while (tag_in_flight(i)) begin
            dispatch_valid = 1'b0;
            @(negedge clock);
            waited++;
            if (waited > 200)
                fail_run($sformatf("tag %0d for row %0d was never released", row_tag(i), i));
        end
        resolve_source(int'(row.src1), a, rs1_tag, rs1_value, m1);
        resolve_source(int'(row.src2), b, rs2_tag, rs2_value, m2);
        exp_val[i]     = alu_model(row.func, m1, m2);
        dispatch_func  = row.func;
        dispatch_dest  = row_tag(i);
        dispatch_valid = 1'b1;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(posedge clock);
            if (!rs_full) begin             // inputs held while full
                taken       = 1'b1;
                accepted[i] = 1'b1;
                if (row.wake) begin
                    compare_bit("cdb_valid", cdb_valid, 1'b1);
                    compare_tag("cdb_tag", cdb_tag, row_tag(int'(row.src1)));
                end
            end
            @(negedge clock);
            waited++;
            if (!taken && waited > 100)
                fail_run($sformatf("row %0d was never accepted by the dispatch port", i));
        end
        dispatch_valid = 1'b0;
    endtask

    // one broadcast seen at a rising edge
    task automatic check_broadcast();
        int owner;
        owner = -1;
        if (cdb_tag == '0)
            fail_run($sformatf("broadcast at %0t carries tag 0", $time));
        for (int r = 0; r < stim.size(); r++)
            if (accepted[r] && !done[r] && row_tag(r) == cdb_tag)
                owner = r;
        if (owner < 0)
            fail_run($sformatf("broadcast at %0t of tag %0d not in flight", $time, cdb_tag));
        if ((stim[owner].src1 >= 0 && !done[stim[owner].src1]) ||
            (stim[owner].src2 >= 0 && !done[stim[owner].src2]))
            fail_run($sformatf("row %0d broadcast before its producers", owner));
        compare_data("cdb_value", cdb_value, exp_val[owner]);
        done[owner] = 1'b1;
    endtask

    always @(posedge clock) begin
        if (!reset) begin
            if (rs_full)
                full_seen = 1'b1;
            if (cdb_valid)
                check_broadcast();
        end
    end

    task automatic wait_all_done();
        int waited;
        int pending;
        waited  = 0;
        pending = 0;
        while (pending >= 0) begin
            pending = -1;
            for (int r = stim.size() - 1; r >= 0; r--)
                if (!done[r])
                    pending = r;            // lowest outstanding row
            if (pending >= 0) begin
                @(negedge clock);
                waited++;
                if (waited > 200)
                    fail_run($sformatf("row %0d (tag %0d) never completed",
                                       pending, row_tag(pending)));
            end
        end
    endtask

    initial begin
        void'($urandom(74));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_func  = ALU_ADD;
        dispatch_dest  = '0;
        rs1_tag        = '0;
        rs1_value      = '0;
        rs2_tag        = '0;
        rs2_value      = '0;
        full_seen      = 1'b0;
        load_table();
        repeat (5) begin
            @(negedge clock);
            compare_bit("cdb_valid", cdb_valid, 1'b0);
            compare_bit("rs_full", rs_full, 1'b0);
        end
        reset = 1'b0;
        @(negedge clock);                   // first cycle out of reset
        compare_bit("cdb_valid", cdb_valid, 1'b0);
        compare_bit("rs_full", rs_full, 1'b0);
        for (int i = 0; i < stim.size(); i++)
            dispatch_row(i);
        wait_all_done();
        if (!full_seen) begin
            fail_run("rs_full never rose during the dependent burst");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- hdl/ooo_issue_top.sv
`timescale 1ns/1ps

// dispatch -> issue -> execute, cdb looped back into the entries
module ooo_issue_top import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  alu_func_e dispatch_func,
    input  rob_tag_t  dispatch_dest,
    input  rob_tag_t  rs1_tag,
    input  data_t     rs1_value,
    input  rob_tag_t  rs2_tag,
    input  data_t     rs2_value,
    output logic      rs_full,
    output logic      cdb_valid,
    output rob_tag_t  cdb_tag,
    output data_t     cdb_value
);

    logic [RS_ENTRIES-1:0] entry_ready;
    logic [RS_ENTRIES-1:0] issue_grant;
    alu_func_e             entry_func [RS_ENTRIES];
    rob_tag_t              entry_dest [RS_ENTRIES];
    data_t                 entry_op1  [RS_ENTRIES];
    data_t                 entry_op2  [RS_ENTRIES];
    logic                  iss_valid;
    alu_func_e             iss_func;
    rob_tag_t              iss_dest;
    data_t                 iss_op1;
    data_t                 iss_op2;

    reservation_station reservation_station_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_func  (dispatch_func),
        .dispatch_dest  (dispatch_dest),
        .rs1_tag        (rs1_tag),
        .rs1_value      (rs1_value),
        .rs2_tag        (rs2_tag),
        .rs2_value      (rs2_value),
        .issue_grant    (issue_grant),
        .cdb_valid      (cdb_valid),   // wakeup path
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .rs_full        (rs_full),
        .entry_ready    (entry_ready),
        .entry_func     (entry_func),
        .entry_dest     (entry_dest),
        .entry_op1      (entry_op1),
        .entry_op2      (entry_op2)
    );

    issue_select issue_select_i (
        .clock       (clock),
        .reset       (reset),
        .entry_ready (entry_ready),
        .entry_func  (entry_func),
        .entry_dest  (entry_dest),
        .entry_op1   (entry_op1),
        .entry_op2   (entry_op2),
        .issue_grant (issue_grant),
        .iss_valid   (iss_valid),
        .iss_func    (iss_func),
        .iss_dest    (iss_dest),
        .iss_op1     (iss_op1),
        .iss_op2     (iss_op2)
    );

    alu_stage alu_stage_i (
        .clock     (clock),
        .reset     (reset),
        .iss_valid (iss_valid),
        .iss_func  (iss_func),
        .iss_dest  (iss_dest),
        .iss_op1   (iss_op1),
        .iss_op2   (iss_op2),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

endmodule

//--- hdl/alu_stage.sv
`timescale 1ns/1ps

// execute and broadcast
// single cycle alu feeding the registered cdb
module alu_stage import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      iss_valid,
    input  alu_func_e iss_func,
    input  rob_tag_t  iss_dest,
    input  data_t     iss_op1,
    input  data_t     iss_op2,
    output logic      cdb_valid,
    output rob_tag_t  cdb_tag,
    output data_t     cdb_value
);

    data_t      alu_result;
    logic [4:0] shamt;      // rv32 style, upper bits of op2 ignored

    assign shamt = iss_op2[4:0];

    always_comb begin
        case (iss_func)
            ALU_ADD: alu_result = iss_op1 + iss_op2;
            ALU_SUB: alu_result = iss_op1 - iss_op2;
            ALU_AND: alu_result = iss_op1 & iss_op2;
            ALU_OR:  alu_result = iss_op1 | iss_op2;
            ALU_XOR: alu_result = iss_op1 ^ iss_op2;
            ALU_SLL: alu_result = iss_op1 << shamt;
            ALU_SRL: alu_result = iss_op1 >> shamt;          // logical
            ALU_SLT: alu_result = data_t'($signed(iss_op1) < $signed(iss_op2));
            default: alu_result = '0;
        endcase
    end

    // broadcast lasts exactly one cycle per issued instruction
    always_ff @(posedge clock) begin
        if (reset)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= iss_valid;
    end

    always_ff @(posedge clock) begin
        if (iss_valid) begin
            cdb_tag   <= iss_dest;
            cdb_value <= alu_result;
        end
    end

    // tag 0 on the bus would wake every resolved source
    a_cdb_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> (cdb_tag != '0));

endmodule

//--- hdl/issue_select.sv
`timescale 1ns/1ps

// issue stage
// fixed priority pick, lowest ready index wins
module issue_select import ooo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [RS_ENTRIES-1:0] entry_ready,
    input  alu_func_e             entry_func [RS_ENTRIES],
    input  rob_tag_t              entry_dest [RS_ENTRIES],
    input  data_t                 entry_op1  [RS_ENTRIES],
    input  data_t                 entry_op2  [RS_ENTRIES],
    output logic [RS_ENTRIES-1:0] issue_grant,
    output logic                  iss_valid,
    output alu_func_e             iss_func,
    output rob_tag_t              iss_dest,
    output data_t                 iss_op1,
    output data_t                 iss_op2
);

    alu_func_e sel_func;
    rob_tag_t  sel_dest;
    data_t     sel_op1;
    data_t     sel_op2;

    // isolate lowest set bit of ready
    assign issue_grant = entry_ready & (~entry_ready + 1'b1);

    // one-hot mux of the granted entry
    always_comb begin
        sel_func = ALU_ADD;
        sel_dest = '0;
        sel_op1  = '0;
        sel_op2  = '0;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (issue_grant[i]) begin
                sel_func = entry_func[i];
                sel_dest = entry_dest[i];
                sel_op1  = entry_op1[i];
                sel_op2  = entry_op2[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            iss_valid <= 1'b0;
        else
            iss_valid <= |issue_grant; // no stall, one issue per cycle
    end

    always_ff @(posedge clock) begin
        if (|issue_grant) begin
            iss_func <= sel_func;
            iss_dest <= sel_dest;
            iss_op1  <= sel_op1;
            iss_op2  <= sel_op2;
        end
    end

    a_grant_legal: assert property (@(posedge clock) disable iff (reset)
        $onehot0(issue_grant) && ((issue_grant & ~entry_ready) == '0));

    // the granted entry is gone by the next cycle, never issued twice
    a_no_reissue: assert property (@(posedge clock) disable iff (reset)
        (issue_grant != '0) |=> ((entry_ready & $past(issue_grant)) == '0));

endmodule

//--- hdl/reservation_station.sv
`timescale 1ns/1ps

// dispatch stage
// steers each accepted instruction into the lowest free entry
module reservation_station import ooo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  alu_func_e             dispatch_func,
    input  rob_tag_t              dispatch_dest,
    input  rob_tag_t              rs1_tag,
    input  data_t                 rs1_value,
    input  rob_tag_t              rs2_tag,
    input  data_t                 rs2_value,
    input  logic [RS_ENTRIES-1:0] issue_grant,  // one-hot clear from issue
    input  logic                  cdb_valid,
    input  rob_tag_t              cdb_tag,
    input  data_t                 cdb_value,
    output logic                  rs_full,
    output logic [RS_ENTRIES-1:0] entry_ready,
    output alu_func_e             entry_func [RS_ENTRIES],
    output rob_tag_t              entry_dest [RS_ENTRIES],
    output data_t                 entry_op1  [RS_ENTRIES],
    output data_t                 entry_op2  [RS_ENTRIES]
);

    logic [RS_ENTRIES-1:0] entry_busy;
    logic [RS_ENTRIES-1:0] free_onehot; // lowest idle entry
    logic [RS_ENTRIES-1:0] entry_wr;
    logic                  dispatch_accept;

    // lowest zero of busy, all zero when full
    assign free_onehot = ~entry_busy & (entry_busy + 1'b1);

    // full comes from registered busy bits only, no same-cycle clear bypass
    assign rs_full         = &entry_busy;
    assign dispatch_accept = dispatch_valid && !rs_full;
    assign entry_wr        = free_onehot & {RS_ENTRIES{dispatch_accept}};

    for (genvar i = 0; i < RS_ENTRIES; i++) begin : g_entry
        rs_entry rs_entry_i (
            .clock        (clock),
            .reset        (reset),
            .wr_en        (entry_wr[i]),
            .clear        (issue_grant[i]),
            .in_func      (dispatch_func),
            .in_dest      (dispatch_dest),
            .in_rs1_tag   (rs1_tag),
            .in_rs1_value (rs1_value),
            .in_rs2_tag   (rs2_tag),
            .in_rs2_value (rs2_value),
            .cdb_valid    (cdb_valid),
            .cdb_tag      (cdb_tag),
            .cdb_value    (cdb_value),
            .busy         (entry_busy[i]),
            .ready        (entry_ready[i]),
            .func         (entry_func[i]),
            .dest         (entry_dest[i]),
            .op1          (entry_op1[i]),
            .op2          (entry_op2[i])
        );
    end

    // writes land only on idle entries
    a_write_idle: assert property (@(posedge clock) disable iff (reset)
        (entry_wr & entry_busy) == '0);

    // an accepted dispatch shows up as one more busy entry next cycle
    // unless issue frees one at the same edge
    a_dispatch_lands: assert property (@(posedge clock) disable iff (reset)
        (dispatch_accept && (issue_grant == '0)) |=>
            ($countones(entry_busy) == $countones($past(entry_busy)) + 1));

endmodule

//--- hdl/rs_entry.sv
`timescale 1ns/1ps

// one reservation station slot
// holds an instruction until both source tags resolve to 0
module rs_entry import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      wr_en,        // load a new instruction
    input  logic      clear,        // issued so free the slot
    input  alu_func_e in_func,
    input  rob_tag_t  in_dest,
    input  rob_tag_t  in_rs1_tag,
    input  data_t     in_rs1_value,
    input  rob_tag_t  in_rs2_tag,
    input  data_t     in_rs2_value,
    input  logic      cdb_valid,
    input  rob_tag_t  cdb_tag,
    input  data_t     cdb_value,
    output logic      busy,
    output logic      ready,
    output alu_func_e func,
    output rob_tag_t  dest,
    output data_t     op1,
    output data_t     op2
);

    rob_tag_t in_tag   [2];     // incoming source tags with index 0 for rs1
    data_t    in_val   [2];
    rob_tag_t src_tag  [2];     // tag still awaited, 0 once resolved
    data_t    src_val  [2];
    rob_tag_t next_tag [2];
    data_t    next_val [2];
    logic     next_busy;

    // live broadcast matches a real tag
    // tag 0 marks a resolved source and never matches the bus
    function automatic logic cdb_hit(input rob_tag_t tag);
        return cdb_valid && (tag != '0) && (cdb_tag == tag);
    endfunction

    assign in_tag[0] = in_rs1_tag;
    assign in_tag[1] = in_rs2_tag;
    assign in_val[0] = in_rs1_value;
    assign in_val[1] = in_rs2_value;

    // same wakeup rule for both sources
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            next_tag[s] = src_tag[s]; // hold by default
            next_val[s] = src_val[s];
            if (wr_en) begin
                // catch a broadcast the map table has not seen yet
                next_tag[s] = cdb_hit(in_tag[s]) ? rob_tag_t'(0) : in_tag[s];
                next_val[s] = cdb_hit(in_tag[s]) ? cdb_value : in_val[s];
            end else if (busy && cdb_hit(src_tag[s])) begin
                next_tag[s] = '0;              // operand arrived
                next_val[s] = cdb_value;
            end
        end
    end

    always_comb begin
        next_busy = busy;
        if (wr_en)
            next_busy = 1'b1;
        else if (clear)
            next_busy = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy    <= 1'b0;
            src_tag <= '{default: '0};
        end else begin
            busy    <= next_busy;
            src_tag <= next_tag;
        end
    end

    // payload is only meaningful while busy
    always_ff @(posedge clock) begin
        if (wr_en) begin
            func <= in_func;
            dest <= in_dest;
        end
        src_val <= next_val;
    end

    assign ready = busy && (src_tag[0] == '0) && (src_tag[1] == '0); // one cycle after load at best
    assign op1   = src_val[0];
    assign op2   = src_val[1];

    // dispatch must never overwrite a live instruction
    a_no_overwrite: assert property (@(posedge clock) disable iff (reset)
        wr_en |-> (!busy || clear));

endmodule

//--- hdl/ooo_pkg.sv
// shared widths and types for the issue subsystem
package ooo_pkg;

    // datapath width
    localparam int XLEN = 32;

    // reorder buffer size, tag 0 is reserved to mean "value present"
    localparam int ROB_LEN = 16;

    // tag width derived from the rob size
    localparam int TAG_BITS = $clog2(ROB_LEN);

    // reservation station depth
    localparam int RS_ENTRIES = 4;

    typedef logic [XLEN-1:0] data_t;        // operand or result value
    typedef logic [TAG_BITS-1:0] rob_tag_t; // rob tag, 0 = ready

    // integer alu operations
    // shifts take the low 5 bits of operand 2
    // slt is a signed compare giving 1 or 0
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_func_e;

endpackage
